//--- wbPkg.sv
`default_nettype none

package wbPkg;

    ////////////////////////////////////////
    // widths fixed by the instruction set
    ////////////////////////////////////////

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int RegCount     = 32;
    localparam int LinkOffset   = 8;    // jal and jalr return past the delay slot

    ////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////

    // how the loaded word is cut down and extended
    typedef enum logic [2:0] {
        loadNone  = 3'd0,
        loadByte  = 3'd1,
        loadByteU = 3'd2,
        loadHalf  = 3'd3,
        loadHalfU = 3'd4,
        loadWord  = 3'd5
    } LoadType;

    // source of the value written back
    typedef enum logic [1:0] {
        selLink = 2'd0,                 // pc plus the link offset
        selAlu  = 2'd1,                 // alu result
        selOutB = 2'd2,                 // second operand, for mthi and mtlo style moves
        selMem  = 2'd3                  // extended load data
    } WbSel;

    // write enables for the three register targets
    typedef struct packed {
        logic rfWr;                     // general register file
        logic hiWr;
        logic loWr;
    } RegsWr;

endpackage

`default_nettype wire

//--- memWbIf.sv
`timescale 1ns/10ps
`default_nettype none

interface memWbIf;

    logic [wbPkg::DataWidth-1:0]    aluOut;
    logic [wbPkg::DataWidth-1:0]    hi;
    logic [wbPkg::DataWidth-1:0]    lo;
    logic [wbPkg::DataWidth-1:0]    pc;
    logic [wbPkg::DataWidth-1:0]    outB;
    logic [wbPkg::DataWidth-1:0]    dmOut;     // raw word from the data memory
    logic [wbPkg::RegAddrWidth-1:0] dst;
    wbPkg::WbSel                    wbSel;
    wbPkg::LoadType                 loadType;
    wbPkg::RegsWr                   regsWr;

    // the MEM stage side
    modport producer (
        output aluOut, hi, lo, pc, outB, dmOut,
        output dst, wbSel, loadType, regsWr
    );

    // the MEM/WB pipeline register side
    modport consumer (
        input aluOut, hi, lo, pc, outB, dmOut,
        input dst, wbSel, loadType, regsWr
    );

endinterface

`default_nettype wire

//--- rfWriteIf.sv
`timescale 1ns/10ps
`default_nettype none

interface rfWriteIf;

    logic [wbPkg::RegAddrWidth-1:0] dst;
    logic [wbPkg::DataWidth-1:0]    result;    // value for the general register
    logic [wbPkg::DataWidth-1:0]    hi;
    logic [wbPkg::DataWidth-1:0]    lo;
    wbPkg::RegsWr                   wr;        // already gated by the write disable

    modport stage (
        output dst, result, hi, lo, wr
    );

    modport file (
        input dst, result, hi, lo, wr
    );

endinterface

`default_nettype wire

//--- wbReg.sv
`timescale 1ns/10ps
`default_nettype none

module wbReg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wbFlush,
    input  logic                          wbWr,
    memWbIf.consumer                      memBus,

    output logic [wbPkg::DataWidth-1:0]    aluOut,
    output logic [wbPkg::DataWidth-1:0]    hi,
    output logic [wbPkg::DataWidth-1:0]    lo,
    output logic [wbPkg::DataWidth-1:0]    pc,
    output logic [wbPkg::DataWidth-1:0]    outB,
    output logic [wbPkg::DataWidth-1:0]    dmOut,
    output logic [wbPkg::RegAddrWidth-1:0] dst,
    output wbPkg::WbSel                    wbSel,
    output wbPkg::LoadType                 loadType,
    output wbPkg::RegsWr                   regsWr
);

    always_ff @(posedge clk) begin
        if (reset || wbFlush) begin                 // flush wins over the stall enable
            aluOut   <= '0;
            hi       <= '0;
            lo       <= '0;
            pc       <= '0;
            outB     <= '0;
            dmOut    <= '0;
            dst      <= '0;
            wbSel    <= wbPkg::selLink;
            loadType <= wbPkg::loadNone;
            regsWr   <= '0;                         // a bubble writes nothing
        end else if (wbWr) begin
            aluOut   <= memBus.aluOut;
            hi       <= memBus.hi;
            lo       <= memBus.lo;
            pc       <= memBus.pc;
            outB     <= memBus.outB;
            dmOut    <= memBus.dmOut;
            dst      <= memBus.dst;
            wbSel    <= memBus.wbSel;
            loadType <= memBus.loadType;
            regsWr   <= memBus.regsWr;
        end
        // with wbWr low the held instruction repeats its write, which is harmless
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a flushed slot must never reach the register file
    flushGivesBubble: assert property (
        @(posedge clk) wbFlush |=> (regsWr == '0)
    ) else $error("wbReg: write enables set in the cycle after a flush");

endmodule

`default_nettype wire

//--- loadExtend.sv
`timescale 1ns/10ps
`default_nettype none

module loadExtend (
    input  logic [wbPkg::DataWidth-1:0] dmOut,
    input  logic [1:0]                  byteAddr,
    input  wbPkg::LoadType              loadType,
    output logic [wbPkg::DataWidth-1:0] dmResult
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    assign byteSel = dmOut[8*byteAddr +: 8];                        // little endian lanes
    assign halfSel = byteAddr[1] ? dmOut[31:16] : dmOut[15:0];      // bit 0 is zero for halfwords

    always_comb begin
        unique case (loadType)
            wbPkg::loadByte: begin
                dmResult = {{(wbPkg::DataWidth-8){byteSel[7]}}, byteSel};
            end
            wbPkg::loadByteU: begin
                dmResult = {{(wbPkg::DataWidth-8){1'b0}}, byteSel};
            end
            wbPkg::loadHalf: begin
                dmResult = {{(wbPkg::DataWidth-16){halfSel[15]}}, halfSel};
            end
            wbPkg::loadHalfU: begin
                dmResult = {{(wbPkg::DataWidth-16){1'b0}}, halfSel};
            end
            default: begin
                dmResult = dmOut;                   // word load, or no load at all
            end
        endcase
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the MEM stage raises an address error before a misaligned halfword gets here
    always_comb begin
        halfAligned: assert final (
            !((loadType == wbPkg::loadHalf || loadType == wbPkg::loadHalfU) && byteAddr[0])
        ) else $error("loadExtend: halfword load at an odd byte address");
    end

endmodule

`default_nettype wire

//--- writebackStage.sv
`timescale 1ns/10ps
`default_nettype none

module writebackStage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wbFlush,
    input  logic                           wbWr,
    input  logic                           wbDisWr,
    memWbIf.consumer                       memBus,
    rfWriteIf.stage                        rfBus,

    output logic [wbPkg::DataWidth-1:0]    wbResult,
    output logic [wbPkg::RegAddrWidth-1:0] wbDst,
    output wbPkg::RegsWr                   wbWrFinal
);

    logic [wbPkg::DataWidth-1:0] wbAluOut;
    logic [wbPkg::DataWidth-1:0] wbHi;
    logic [wbPkg::DataWidth-1:0] wbLo;
    logic [wbPkg::DataWidth-1:0] wbPc;
    logic [wbPkg::DataWidth-1:0] wbOutB;
    logic [wbPkg::DataWidth-1:0] wbDmOut;
    logic [wbPkg::DataWidth-1:0] wbDmResult;
    wbPkg::WbSel                 wbSel;
    wbPkg::LoadType              wbLoadType;
    wbPkg::RegsWr                wbRegsWr;

    wbReg u_wbReg (
        .clk      (clk),
        .reset    (reset),
        .wbFlush  (wbFlush),
        .wbWr     (wbWr),
        .memBus   (memBus),
        .aluOut   (wbAluOut),
        .hi       (wbHi),
        .lo       (wbLo),
        .pc       (wbPc),
        .outB     (wbOutB),
        .dmOut    (wbDmOut),
        .dst      (wbDst),
        .wbSel    (wbSel),
        .loadType (wbLoadType),
        .regsWr   (wbRegsWr)
    );

    loadExtend u_loadExtend (
        .dmOut    (wbDmOut),
        .byteAddr (wbAluOut[1:0]),                  // the alu computed the load address
        .loadType (wbLoadType),
        .dmResult (wbDmResult)
    );

    ////////////////////////////////////////
    // result select and write gating
    ////////////////////////////////////////

    always_comb begin
        unique case (wbSel)
            wbPkg::selLink: wbResult = wbPc + wbPkg::DataWidth'(wbPkg::LinkOffset);
            wbPkg::selAlu:  wbResult = wbAluOut;
            wbPkg::selOutB: wbResult = wbOutB;
            default:        wbResult = wbDmResult;
        endcase
    end

    assign wbWrFinal = wbDisWr ? '0 : wbRegsWr;    // the data cache is holding the pipeline

    assign rfBus.dst    = wbDst;
    assign rfBus.result = wbResult;
    assign rfBus.hi     = wbHi;
    assign rfBus.lo     = wbLo;
    assign rfBus.wr     = wbWrFinal;

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                           clk,
    input  logic                           reset,
    rfWriteIf.file                         rfBus,
    input  logic [wbPkg::RegAddrWidth-1:0] rsAddr,
    input  logic [wbPkg::RegAddrWidth-1:0] rtAddr,

    output logic [wbPkg::DataWidth-1:0]    rsData,
    output logic [wbPkg::DataWidth-1:0]    rtData,
    output logic [wbPkg::DataWidth-1:0]    hiData,
    output logic [wbPkg::DataWidth-1:0]    loData
);

    logic [wbPkg::DataWidth-1:0] regs [wbPkg::RegCount];
    logic [wbPkg::DataWidth-1:0] hiReg;
    logic [wbPkg::DataWidth-1:0] loReg;
    logic                        rfWrLive;

    assign rfWrLive = rfBus.wr.rfWr && (rfBus.dst != '0);   // register 0 swallows writes

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < wbPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (rfWrLive) begin
                regs[rfBus.dst] <= rfBus.result;
            end
            if (rfBus.wr.hiWr) begin
                hiReg <= rfBus.hi;
            end
            if (rfBus.wr.loWr) begin
                loReg <= rfBus.lo;
            end
        end
    end

    ////////////////////////////////////////
    // reads with same-cycle bypass
    ////////////////////////////////////////

    // register 0 keeps its reset value because it is never written
    assign rsData = (rfWrLive && rfBus.dst == rsAddr) ? rfBus.result : regs[rsAddr];
    assign rtData = (rfWrLive && rfBus.dst == rtAddr) ? rfBus.result : regs[rtAddr];
    assign hiData = rfBus.wr.hiWr ? rfBus.hi : hiReg;
    assign loData = rfBus.wr.loWr ? rfBus.lo : loReg;

    // holds through the bypass even when the stage writes to register 0
    zeroReadsZero: assert property (
        @(posedge clk) disable iff (reset)
        ((rsAddr != '0) || (rsData == '0)) && ((rtAddr != '0) || (rtData == '0))
    ) else $error("regFile: register 0 read back a nonzero value");

endmodule

`default_nettype wire

//--- wbSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module wbSubsystem (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wbFlush,
    input  logic                           wbWr,
    input  logic                           wbDisWr,
    input  logic [wbPkg::DataWidth-1:0]    memAluOut,
    input  logic [wbPkg::DataWidth-1:0]    memHi,
    input  logic [wbPkg::DataWidth-1:0]    memLo,
    input  logic [wbPkg::DataWidth-1:0]    memPc,
    input  logic [wbPkg::DataWidth-1:0]    memOutB,
    input  logic [wbPkg::DataWidth-1:0]    memDmOut,
    input  logic [wbPkg::RegAddrWidth-1:0] memDst,
    input  logic [1:0]                     memWbSel,
    input  logic [2:0]                     memLoadType,
    input  logic                           memRfWr,
    input  logic                           memHiWr,
    input  logic                           memLoWr,
    input  logic [wbPkg::RegAddrWidth-1:0] rsAddr,
    input  logic [wbPkg::RegAddrWidth-1:0] rtAddr,

    output logic [wbPkg::DataWidth-1:0]    wbResult,
    output logic [wbPkg::RegAddrWidth-1:0] wbDst,
    output logic                           rfWrEn,
    output logic                           hiWrEn,
    output logic                           loWrEn,
    output logic [wbPkg::DataWidth-1:0]    rsData,
    output logic [wbPkg::DataWidth-1:0]    rtData,
    output logic [wbPkg::DataWidth-1:0]    hiData,
    output logic [wbPkg::DataWidth-1:0]    loData
);

    memWbIf       memBus ();
    rfWriteIf     rfBus ();
    wbPkg::RegsWr wbWrFinal;

    ////////////////////////////////////////
    // MEM stage fields onto the bus
    ////////////////////////////////////////

    assign memBus.aluOut   = memAluOut;
    assign memBus.hi       = memHi;
    assign memBus.lo       = memLo;
    assign memBus.pc       = memPc;
    assign memBus.outB     = memOutB;
    assign memBus.dmOut    = memDmOut;
    assign memBus.dst      = memDst;
    assign memBus.wbSel    = wbPkg::WbSel'(memWbSel);
    assign memBus.loadType = wbPkg::LoadType'(memLoadType);
    assign memBus.regsWr   = '{rfWr: memRfWr, hiWr: memHiWr, loWr: memLoWr};

    writebackStage u_writebackStage (
        .clk       (clk),
        .reset     (reset),
        .wbFlush   (wbFlush),
        .wbWr      (wbWr),
        .wbDisWr   (wbDisWr),
        .memBus    (memBus.consumer),
        .rfBus     (rfBus.stage),
        .wbResult  (wbResult),
        .wbDst     (wbDst),
        .wbWrFinal (wbWrFinal)
    );

    regFile u_regFile (
        .clk    (clk),
        .reset  (reset),
        .rfBus  (rfBus.file),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .hiData (hiData),
        .loData (loData)
    );

    assign rfWrEn = wbWrFinal.rfWr;
    assign hiWrEn = wbWrFinal.hiWr;
    assign loWrEn = wbWrFinal.loWr;

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;   // 10 ns period

endmodule

`default_nettype wire

//--- tbWriteback.sv
`timescale 1ns/10ps
`default_nettype none

module tbWriteback;

    localparam int NumCycles      = 3000;
    localparam int ResetCycles    = 5;
    localparam int ClkPeriod      = 10;
    localparam int WatchdogMargin = 1000;

    logic        clk, reset, wbFlush, wbWr, wbDisWr;
    logic [31:0] memAluOut, memHi, memLo, memPc, memOutB, memDmOut;
    logic [4:0]  memDst, rsAddr, rtAddr;
    logic [1:0]  memWbSel;
    logic [2:0]  memLoadType;
    logic        memRfWr, memHiWr, memLoWr;
    logic [31:0] wbResult, rsData, rtData, hiData, loData;
    logic [4:0]  wbDst;
    logic        rfWrEn, hiWrEn, loWrEn;

    // model of the MEM/WB register, bit order of the write enables is rf, hi, lo
    logic [31:0] pAluOut, pHi, pLo, pPc, pOutB, pDmOut;
    logic [4:0]  pDst;
    logic [1:0]  pSel;
    logic [2:0]  pLoad, pWr;
    logic [31:0] modelRegs [32];
    logic [31:0] modelHi, modelLo;
    logic [31:0] curResult, lastResult;
    logic [2:0]  curWr;
    logic [4:0]  lastDst;
    logic        prevFlush, prevHold;

    tbClock u_tbClock (.clk(clk));

    wbSubsystem u_wbSubsystem (
        .clk(clk), .reset(reset), .wbFlush(wbFlush), .wbWr(wbWr), .wbDisWr(wbDisWr),
        .memAluOut(memAluOut), .memHi(memHi), .memLo(memLo), .memPc(memPc),
        .memOutB(memOutB), .memDmOut(memDmOut), .memDst(memDst), .memWbSel(memWbSel),
        .memLoadType(memLoadType), .memRfWr(memRfWr), .memHiWr(memHiWr), .memLoWr(memLoWr),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .wbResult(wbResult), .wbDst(wbDst),
        .rfWrEn(rfWrEn), .hiWrEn(hiWrEn), .loWrEn(loWrEn), .rsData(rsData),
        .rtData(rtData), .hiData(hiData), .loData(loData)
    );

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // shift the addressed lane down to bit 0, then cut and extend
    function automatic logic [31:0] extendLoad(input logic [31:0] word, input logic [1:0] addr,
                                               input logic [2:0] kind);
        logic [31:0] shifted;
        shifted = word >> {addr, 3'b000};
        case (kind)
            3'd1:    return {{24{shifted[7]}}, shifted[7:0]};
            3'd2:    return {24'd0, shifted[7:0]};
            3'd3:    return {{16{shifted[15]}}, shifted[15:0]};
            3'd4:    return {16'd0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] selectResult(input logic [1:0] sel);
        case (sel)
            2'd0:    return pPc + 32'd8;                // link skips the delay slot
            2'd1:    return pAluOut;
            2'd2:    return pOutB;
            default: return extendLoad(pDmOut, pAluOut[1:0], pLoad);
        endcase
    endfunction

    ////////////////////////////////////////
    // stimulus, checks and model update
    ////////////////////////////////////////

    task automatic driveInputs();
        wbFlush     = ($urandom_range(99) < 5);
        wbWr        = ($urandom_range(99) >= 15);
        wbDisWr     = ($urandom_range(99) < 10);
        memAluOut   = $urandom();
        memHi       = $urandom();
        memLo       = $urandom();
        memPc       = $urandom();
        memOutB     = $urandom();
        memDmOut    = $urandom();
        memDst      = 5'($urandom());
        memWbSel    = 2'($urandom());
        memLoadType = 3'($urandom_range(5));
        memRfWr     = 1'($urandom());
        memHiWr     = 1'($urandom());
        memLoWr     = 1'($urandom());
        rsAddr      = 5'($urandom());
        rtAddr      = 5'($urandom());
        if (memLoadType == 3'd3 || memLoadType == 3'd4) begin
            memAluOut[0] = 1'b0;                        // halfword loads stay aligned
        end
    endtask

    task automatic checkOutputs();
        logic        rfLive;
        logic [31:0] expRs, expRt;
        curResult = selectResult(pSel);
        curWr     = wbDisWr ? 3'b000 : pWr;
        rfLive    = curWr[2] && (pDst != 5'd0);
        expRs = (rsAddr == 5'd0) ? 32'd0 : (rfLive && pDst == rsAddr) ? curResult : modelRegs[rsAddr];
        expRt = (rtAddr == 5'd0) ? 32'd0 : (rfLive && pDst == rtAddr) ? curResult : modelRegs[rtAddr];
        checkEq(wbResult, curResult, "wbResult");
        checkEq({27'd0, wbDst}, {27'd0, pDst}, "wbDst");
        checkEq({29'd0, rfWrEn, hiWrEn, loWrEn}, {29'd0, curWr}, "write enables");
        checkEq(rsData, expRs, "rsData");
        checkEq(rtData, expRt, "rtData");
        checkEq(hiData, curWr[1] ? pHi : modelHi, "hiData");
        checkEq(loData, curWr[0] ? pLo : modelLo, "loData");
        if (prevFlush) begin
            checkEq({29'd0, rfWrEn, hiWrEn, loWrEn}, 32'd0, "enables after flush");
        end
        if (prevHold) begin                             // stalled, so the slot must not move
            checkEq(wbResult, lastResult, "wbResult under stall");
            checkEq({27'd0, wbDst}, {27'd0, lastDst}, "wbDst under stall");
        end
        lastResult = wbResult;
        lastDst    = wbDst;
        prevFlush  = wbFlush;
        prevHold   = !wbWr && !wbFlush;
    endtask

    task automatic updateModel();
        if (curWr[2] && pDst != 5'd0) modelRegs[pDst] = curResult;
        if (curWr[1]) modelHi = pHi;
        if (curWr[0]) modelLo = pLo;
        if (wbFlush) begin
            {pAluOut, pHi, pLo, pPc, pOutB, pDmOut} = '0;
            {pDst, pSel, pLoad, pWr} = '0;
        end else if (wbWr) begin
            {pAluOut, pHi, pLo, pPc, pOutB, pDmOut} =
                {memAluOut, memHi, memLo, memPc, memOutB, memDmOut};
            {pDst, pSel, pLoad, pWr} =
                {memDst, memWbSel, memLoadType, memRfWr, memHiWr, memLoWr};
        end
    endtask

    initial begin
        void'($urandom(32'h9e96));
        reset = 1'b1;
        {wbFlush, wbWr, wbDisWr, memRfWr, memHiWr, memLoWr} = '0;
        {memAluOut, memHi, memLo, memPc, memOutB, memDmOut} = '0;
        {memDst, rsAddr, rtAddr, memWbSel, memLoadType} = '0;
        {pAluOut, pHi, pLo, pPc, pOutB, pDmOut, modelHi, modelLo} = '0;
        {pDst, pSel, pLoad, pWr} = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        {prevFlush, prevHold} = 2'b00;
        repeat (ResetCycles) @(negedge clk);
        reset = 1'b0;
        for (int cycle = 0; cycle < NumCycles; cycle++) begin
            driveInputs();
            #1;                                         // let the combinational paths settle
            checkOutputs();
            @(posedge clk);
            updateModel();
            @(negedge clk);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        #((ResetCycles + NumCycles) * ClkPeriod + WatchdogMargin);
        $display("watchdog expired before the random test loop finished");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- compile.f
wbPkg.sv
memWbIf.sv
rfWriteIf.sv
wbReg.sv
loadExtend.sv
writebackStage.sv
regFile.sv
wbSubsystem.sv
tbClock.sv
tbWriteback.sv

//--- Makefile
TOP = tbWriteback

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
